//--- nocDefs_defs.svh
`ifndef NOCDEFS_DEFS_SVH
`define NOCDEFS_DEFS_SVH

// flit payload word
`define FLIT_W 32

// packet length field, also the timer count width
`define LEN_W 12

// flit identifier carried next to each word
`define FID_W 3

`endif

//--- flitPkg.sv
`include "nocDefs_defs.svh"

package flitPkg;

  typedef enum logic [`FID_W-1:0]
  {
    FID_NONE = 3'd0,
    FID_HEAD = 3'd1, // loads the packet timer
    FID_BODY = 3'd2,
    FID_TAIL = 3'd3
  } flitId_t;

  // also the grant bit position
  typedef enum logic [2:0]
  {
    DIR_L = 3'd0,
    DIR_N = 3'd1,
    DIR_E = 3'd2,
    DIR_W = 3'd3,
    DIR_S = 3'd4
  } dir_t;

endpackage

//--- arbPkg.sv
package arbPkg;

  // one-hot, bits 5:1 form the grant vector
  typedef enum logic [5:0]
  {
    ST_IDLE = 6'b000001,
    ST_L    = 6'b000010,
    ST_N    = 6'b000100,
    ST_E    = 6'b001000,
    ST_W    = 6'b010000,
    ST_S    = 6'b100000
  } arbState_t;

endpackage

//--- packetTimer.sv
`timescale 1ns/1ns
`include "nocDefs_defs.svh"

module packetTimer
(
  input  logic              clk,
  input  logic              rst,
  input  logic [`FID_W-1:0] flitId,
  input  logic [`LEN_W-1:0] length,
  input  logic              run,
  output logic              timesUp
);

  import flitPkg::*;

  logic [`LEN_W-1:0] limit;
  logic [`LEN_W-1:0] count;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      limit <= '0;
      count <= '0;
    end
    else
    begin
      if (flitId == FID_HEAD) // length only valid on header
        limit <= length;
      if (run)
        count <= count + 1'b1;
      else
        count <= '0; // restart on every new hold
    end
  end

  // holder has used its slot
  assign timesUp = (count == limit);

endmodule

//--- portArbiter.sv
`timescale 1ns/1ns
`include "nocDefs_defs.svh"

module portArbiter
(
  input  logic              clk,
  input  logic              rst,
  input  logic              LReq,
  input  logic              NReq,
  input  logic              EReq,
  input  logic              WReq,
  input  logic              SReq,
  input  logic [`FID_W-1:0] LFlitId,
  input  logic [`FID_W-1:0] NFlitId,
  input  logic [`FID_W-1:0] EFlitId,
  input  logic [`FID_W-1:0] WFlitId,
  input  logic [`FID_W-1:0] SFlitId,
  input  logic [`LEN_W-1:0] LLength,
  input  logic [`LEN_W-1:0] NLength,
  input  logic [`LEN_W-1:0] ELength,
  input  logic [`LEN_W-1:0] WLength,
  input  logic [`LEN_W-1:0] SLength,
  output logic [4:0]        grant
);

  import flitPkg::*;
  import arbPkg::*;

  arbState_t  state;
  arbState_t  nextState;
  dir_t       holder;
  logic [4:0] reqVec;
  logic [4:0] upVec;
  logic [4:0] runVec;

  assign reqVec = {SReq, WReq, EReq, NReq, LReq};

  // Search starts right after last and wraps, so last is tried at the end.
  // Walking downwards lets the nearest requester overwrite the farther ones.
  function automatic arbState_t rotatePick(input logic [4:0] req, input dir_t last);
    arbState_t  pick;
    logic [2:0] idx;
    pick = ST_IDLE;
    for (int k = 5; k >= 1; k--)
    begin
      idx = 3'((int'(last) + k) % 5);
      if (req[idx])
        pick = arbState_t'(6'b000010 << idx);
    end
    return pick;
  endfunction

  packetTimer i_timerL
  (
    .clk     (clk),
    .rst     (rst),
    .flitId  (LFlitId),
    .length  (LLength),
    .run     (runVec[0]),
    .timesUp (upVec[0])
  );

  packetTimer i_timerN
  (
    .clk     (clk),
    .rst     (rst),
    .flitId  (NFlitId),
    .length  (NLength),
    .run     (runVec[1]),
    .timesUp (upVec[1])
  );

  packetTimer i_timerE
  (
    .clk     (clk),
    .rst     (rst),
    .flitId  (EFlitId),
    .length  (ELength),
    .run     (runVec[2]),
    .timesUp (upVec[2])
  );

  packetTimer i_timerW
  (
    .clk     (clk),
    .rst     (rst),
    .flitId  (WFlitId),
    .length  (WLength),
    .run     (runVec[3]),
    .timesUp (upVec[3])
  );

  packetTimer i_timerS
  (
    .clk     (clk),
    .rst     (rst),
    .flitId  (SFlitId),
    .length  (SLength),
    .run     (runVec[4]),
    .timesUp (upVec[4])
  );

  always_comb
  begin
    case (state)
      ST_N:    holder = DIR_N;
      ST_E:    holder = DIR_E;
      ST_W:    holder = DIR_W;
      ST_S:    holder = DIR_S;
      default: holder = DIR_L; // idle never reads it
    endcase
  end

  always_comb
  begin
    runVec    = '0;
    nextState = ST_IDLE;
    case (state)
      ST_IDLE:
        nextState = rotatePick(reqVec, DIR_S); // L goes first
      ST_L, ST_N, ST_E, ST_W, ST_S:
      begin
        if (reqVec[holder] && !upVec[holder])
        begin
          runVec[holder] = 1'b1;
          nextState      = state;
        end
        else
          nextState = rotatePick(reqVec, holder);
      end
      default:
        nextState = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      state <= ST_IDLE;
    else
      state <= nextState;
  end

  assign grant = state[5:1]; // drop idle bit

endmodule

//--- linkOutput.sv
`timescale 1ns/1ns
`include "nocDefs_defs.svh"

module linkOutput
(
  input  logic               clk,
  input  logic               rst,
  input  logic [4:0]         grant,
  input  logic [`FLIT_W-1:0] LData,
  input  logic [`FLIT_W-1:0] NData,
  input  logic [`FLIT_W-1:0] EData,
  input  logic [`FLIT_W-1:0] WData,
  input  logic [`FLIT_W-1:0] SData,
  output logic [`FLIT_W-1:0] outData,
  output logic               outValid,
  output flitPkg::dir_t      outPort
);

  import flitPkg::*;

  dir_t               selDir;
  logic [`FLIT_W-1:0] selData;

  always_comb
  begin
    case (grant)
      5'b00010: selDir = DIR_N;
      5'b00100: selDir = DIR_E;
      5'b01000: selDir = DIR_W;
      5'b10000: selDir = DIR_S;
      default:  selDir = DIR_L; // also covers no grant
    endcase
  end

  always_comb
  begin
    case (selDir)
      DIR_N:   selData = NData;
      DIR_E:   selData = EData;
      DIR_W:   selData = WData;
      DIR_S:   selData = SData;
      default: selData = LData;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      outValid <= 1'b0;
      outPort  <= DIR_L;
    end
    else
    begin
      outValid <= |grant;
      if (|grant)
        outPort <= selDir; // keep last port while idle
    end
  end

  always_ff @(posedge clk)
  begin
    if (|grant)
      outData <= selData;
  end

endmodule

//--- routerOutPort.sv
`timescale 1ns/1ns
`include "nocDefs_defs.svh"

module routerOutPort
(
  input  logic               clk,
  input  logic               rst,
  input  logic               LReq,
  input  logic               NReq,
  input  logic               EReq,
  input  logic               WReq,
  input  logic               SReq,
  input  logic [`FID_W-1:0]  LFlitId,
  input  logic [`FID_W-1:0]  NFlitId,
  input  logic [`FID_W-1:0]  EFlitId,
  input  logic [`FID_W-1:0]  WFlitId,
  input  logic [`FID_W-1:0]  SFlitId,
  input  logic [`LEN_W-1:0]  LLength,
  input  logic [`LEN_W-1:0]  NLength,
  input  logic [`LEN_W-1:0]  ELength,
  input  logic [`LEN_W-1:0]  WLength,
  input  logic [`LEN_W-1:0]  SLength,
  input  logic [`FLIT_W-1:0] LData,
  input  logic [`FLIT_W-1:0] NData,
  input  logic [`FLIT_W-1:0] EData,
  input  logic [`FLIT_W-1:0] WData,
  input  logic [`FLIT_W-1:0] SData,
  output logic [4:0]         grant,
  output logic [`FLIT_W-1:0] outData,
  output logic               outValid,
  output flitPkg::dir_t      outPort
);

  portArbiter i_portArbiter
  (
    .clk     (clk),
    .rst     (rst),
    .LReq    (LReq),
    .NReq    (NReq),
    .EReq    (EReq),
    .WReq    (WReq),
    .SReq    (SReq),
    .LFlitId (LFlitId),
    .NFlitId (NFlitId),
    .EFlitId (EFlitId),
    .WFlitId (WFlitId),
    .SFlitId (SFlitId),
    .LLength (LLength),
    .NLength (NLength),
    .ELength (ELength),
    .WLength (WLength),
    .SLength (SLength),
    .grant   (grant)
  );

  linkOutput i_linkOutput
  (
    .clk      (clk),
    .rst      (rst),
    .grant    (grant), // registered, so data lands a cycle later
    .LData    (LData),
    .NData    (NData),
    .EData    (EData),
    .WData    (WData),
    .SData    (SData),
    .outData  (outData),
    .outValid (outValid),
    .outPort  (outPort)
  );

endmodule

//--- routerOutPort_assert.sv
`timescale 1ns/1ns

module arbAssert
(
  input logic       clk,
  input logic       rst,
  input logic [4:0] grant,
  input logic [4:0] req
);

  // at most one direction owns the link
  grantOneHot: assert property (@(posedge clk) disable iff (rst) $onehot0(grant))
    else $error("grant %b has more than one bit set", grant);

  grantClearAfterReset: assert property (@(posedge clk) rst |=> grant == 5'd0)
    else $error("grant %b not cleared after reset", grant);

  // owner either asked last cycle or already held the link
  grantFromRequest: assert property (@(posedge clk) disable iff (rst)
    (grant != 5'd0) |-> ((grant & ($past(req) | $past(grant))) != 5'd0))
    else $error("grant %b given without a request", grant);

endmodule

bind portArbiter arbAssert i_arbAssert
(
  .clk   (clk),
  .rst   (rst),
  .grant (grant),
  .req   (reqVec)
);

//--- routerOutPort_tb.sv
`timescale 1ns/1ns
`include "nocDefs_defs.svh"

module routerOutPort_tb;

  import flitPkg::*;

  logic               clk;
  logic               rst;
  logic [4:0]         req;
  logic [`FID_W-1:0]  fid [5];
  logic [`LEN_W-1:0]  len [5];
  logic [`FLIT_W-1:0] data [5];
  logic [4:0]         grant;
  logic [`FLIT_W-1:0] outData;
  logic               outValid;
  dir_t               outPort;

  logic [4:0]         mGrant; // model of the arbiter
  logic               mValid;
  logic [2:0]         mPort;
  logic [`FLIT_W-1:0] mData;
  logic [`LEN_W-1:0]  mCount [5];
  logic [`LEN_W-1:0]  mLimit [5];

  integer     seed;
  string      curTest;
  int         testErrs;
  int         errCount;
  int         nTests;
  int         nFailedTests;
  int         held;
  int         cyc;
  logic [2:0] dirIdx;
  logic [2:0] step;

  routerOutPort i_routerOutPort
  (
    .clk (clk), .rst (rst),
    .LReq (req[0]), .NReq (req[1]), .EReq (req[2]), .WReq (req[3]), .SReq (req[4]),
    .LFlitId (fid[0]), .NFlitId (fid[1]), .EFlitId (fid[2]),
    .WFlitId (fid[3]), .SFlitId (fid[4]),
    .LLength (len[0]), .NLength (len[1]), .ELength (len[2]),
    .WLength (len[3]), .SLength (len[4]),
    .LData (data[0]), .NData (data[1]), .EData (data[2]),
    .WData (data[3]), .SData (data[4]),
    .grant (grant), .outData (outData), .outValid (outValid), .outPort (outPort)
  );

  always #4 clk = ~clk;

  function automatic logic [2:0] dirOf(input logic [4:0] g);
    logic [2:0] i;
    logic [2:0] r;
    r = 3'd0;
    for (i = 3'd0; i < 3'd5; i++)
      if (g[i])
        r = i;
    return r;
  endfunction

  // rotating priority, the holder itself is tried last
  function automatic logic [4:0] nextGrant(input logic [4:0] cur, input logic [4:0] r,
                                           input logic [`LEN_W-1:0] cnt [5],
                                           input logic [`LEN_W-1:0] lim [5]);
    logic [2:0] last;
    logic [2:0] k;
    logic [2:0] idx;
    logic [4:0] pick;
    last = (cur == 5'd0) ? 3'd4 : dirOf(cur); // idle starts at L
    if (cur != 5'd0 && r[last] && cnt[last] != lim[last])
      return cur;
    pick = 5'd0;
    for (k = 3'd1; k <= 3'd5; k++)
    begin
      idx = 3'((int'(last) + int'(k)) % 5);
      if (pick == 5'd0 && r[idx])
        pick = 5'd1 << idx;
    end
    return pick;
  endfunction

  task automatic reportErr(input string sig, input logic [31:0] expv, input logic [31:0] actv);
    $display("FAILED %s %s expected %0h actual %0h", curTest, sig, expv, actv);
    errCount++;
    testErrs++;
  endtask

  task automatic beginTest(input string name);
    curTest  = name;
    testErrs = 0;
  endtask

  task automatic finishTest();
    nTests++;
    if (testErrs == 0)
      $display("test %s done, no errors", curTest);
    else
    begin
      nFailedTests++;
      $display("test %s done, %0d errors", curTest, testErrs);
    end
  endtask

  task automatic waitGrant(input logic [4:0] want, input int maxCycles);
    int n;
    n = 0;
    @(negedge clk);
    while (grant !== want && n < maxCycles)
    begin
      n++;
      @(negedge clk);
    end
    if (grant !== want)
    begin
      $display("timed out in test %s waiting for grant %b, grant is %b", curTest, want, grant);
      $display("sim failed");
      $finish;
    end
  endtask

  always @(posedge clk)
  begin
    logic [4:0] nxt;
    logic [2:0] d;
    logic       holding;
    if (rst)
    begin
      mGrant = 5'd0;
      mValid = 1'b0;
      mPort  = 3'd0;
      for (d = 3'd0; d < 3'd5; d++)
      begin
        mCount[d] = '0;
        mLimit[d] = '0;
      end
    end
    else
    begin
      nxt    = nextGrant(mGrant, req, mCount, mLimit);
      mValid = (mGrant != 5'd0);
      if (mGrant != 5'd0)
      begin
        mPort = dirOf(mGrant);
        mData = data[dirOf(mGrant)];
      end
      for (d = 3'd0; d < 3'd5; d++)
      begin
        holding   = mGrant[d] && req[d] && (mCount[d] != mLimit[d]);
        mCount[d] = holding ? mCount[d] + 12'd1 : '0;
        if (fid[d] == FID_HEAD)
          mLimit[d] = len[d];
      end
      mGrant = nxt;
    end
  end

  always @(negedge clk)
  begin
    if (!rst)
    begin
      if (grant !== mGrant)
        reportErr("grant", 32'(mGrant), 32'(grant));
      if (outValid !== mValid)
        reportErr("outValid", 32'(mValid), 32'(outValid));
      if (outPort !== mPort)
        reportErr("outPort", 32'(mPort), 32'(outPort));
      if (mValid && outData !== mData)
        reportErr("outData", mData, outData);
    end
  end

  initial
  begin
    clk          = 1'b0;
    seed         = 36;
    errCount     = 0;
    nTests       = 0;
    nFailedTests = 0;
    curTest      = "reset";
    rst <= 1'b1;
    req <= '0;
    for (dirIdx = 3'd0; dirIdx < 3'd5; dirIdx++)
    begin
      fid[dirIdx]  <= FID_NONE;
      len[dirIdx]  <= '0;
      data[dirIdx] <= '0;
    end
    repeat (4) @(posedge clk);
    rst <= 1'b0;

    beginTest("idleAfterReset");
    repeat (6)
    begin
      @(negedge clk);
      if (grant !== 5'd0)
        reportErr("grant", 32'd0, 32'(grant));
      if (outValid !== 1'b0)
        reportErr("outValid", 32'd0, 32'(outValid));
    end
    finishTest();

    beginTest("allRequest");
    @(posedge clk);
    req <= 5'b11111;
    for (dirIdx = 3'd0; dirIdx < 3'd5; dirIdx++)
      data[dirIdx] <= 32'hd000_0000 + 32'(dirIdx);
    waitGrant(5'b00001, 5);
    for (step = 3'd1; step <= 3'd5; step++)
    begin
      @(negedge clk);
      if (grant !== (5'd1 << (step % 3'd5))) // zero length, new owner each cycle
        reportErr("rotation", 32'(5'd1 << (step % 3'd5)), 32'(grant));
    end
    @(posedge clk);
    req <= '0;
    waitGrant(5'd0, 4);
    finishTest();

    beginTest("soleHolder");
    @(posedge clk);
    req    <= 5'b00001;
    fid[0] <= FID_HEAD;
    len[0] <= 12'd3;
    @(posedge clk);
    fid[0] <= FID_BODY;
    waitGrant(5'b00001, 4);
    repeat (12)
    begin
      @(posedge clk);
      data[0] <= data[0] + 32'd1;
      @(negedge clk);
      if (grant !== 5'b00001)
        reportErr("soleGrant", 32'd1, 32'(grant));
    end
    finishTest();

    beginTest("holdLimit");
    @(posedge clk);
    req <= 5'b00011;
    waitGrant(5'b00010, 10);
    waitGrant(5'b00001, 4);
    held = 1;
    @(negedge clk);
    while (grant === 5'b00001 && held < 50)
    begin
      held++;
      @(negedge clk);
    end
    if (held != 4) // length 3 gives four cycles
      reportErr("holdCycles", 32'd4, 32'(held));
    finishTest();

    beginTest("dropHolder");
    @(posedge clk);
    req <= 5'b10101;
    for (dirIdx = 3'd0; dirIdx < 3'd5; dirIdx += 3'd2)
    begin
      fid[dirIdx] <= FID_HEAD;
      len[dirIdx] <= 12'd10;
    end
    @(posedge clk);
    for (dirIdx = 3'd0; dirIdx < 3'd5; dirIdx += 3'd2)
      fid[dirIdx] <= FID_BODY;
    waitGrant(5'b00001, 20);
    @(posedge clk);
    req[0] <= 1'b0;
    waitGrant(5'b00100, 3);
    @(posedge clk);
    req[2] <= 1'b0;
    waitGrant(5'b10000, 3);
    @(posedge clk);
    req[4] <= 1'b0;
    waitGrant(5'd0, 3);
    finishTest();

    beginTest("randomRun");
    for (cyc = 0; cyc < 500; cyc++)
    begin
      @(posedge clk);
      req <= 5'($random(seed));
      for (dirIdx = 3'd0; dirIdx < 3'd5; dirIdx++)
      begin
        fid[dirIdx]  <= {1'b0, 2'($random(seed))};
        len[dirIdx]  <= {9'd0, 3'($random(seed))}; // 0 to 7
        data[dirIdx] <= $random(seed);
      end
    end
    @(posedge clk);
    req <= '0;
    repeat (3) @(negedge clk);
    finishTest();

    $display("tests %0d, failed tests %0d, errors %0d", nTests, nFailedTests, errCount);
    if (errCount == 0)
      $display("sim passed");
    else
      $display("sim failed");
    $finish;
  end

endmodule

//--- list.f
+incdir+.
flitPkg.sv
arbPkg.sv
packetTimer.sv
portArbiter.sv
linkOutput.sv
routerOutPort.sv
routerOutPort_assert.sv
routerOutPort_tb.sv

//--- Makefile
# Verilator build and run for the router output port testbench

VERILATOR ?= verilator
TOP       ?= routerOutPort_tb
FILELIST  ?= list.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= sim passed
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(filter-out +%,$(shell cat $(FILELIST))) nocDefs_defs.svh
BIN  := $(OBJDIR)/V$(TOP)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJDIR) $(LOG)
